/* DecodeStage.sv */
// Decode stage: field split, register file with write bypass, immediate sign extension
`timescale 1ns/1ps

module DecodeStage (
	input  logic clk,
	input  logic rst_n,
	input  pipePkg::ifIdT ifId,
	input  pipePkg::memWbT wbWrite,
	output pipePkg::idExT idEx,
	output logic [isaPkg::REG_ADDR_W-1:0] rsIdx,
	output logic [isaPkg::REG_ADDR_W-1:0] srcIdx,
	output logic useSrc
);

	logic [isaPkg::DATA_W-1:0] regs [isaPkg::REG_COUNT];
	logic [isaPkg::OP_W-1:0] opField;
	isaPkg::opcodeT op;
	logic [isaPkg::REG_ADDR_W-1:0] rdIdx;
	logic [isaPkg::REG_ADDR_W-1:0] rtIdx;
	logic [isaPkg::DATA_W-1:0] rsVal;
	logic [isaPkg::DATA_W-1:0] srcVal;
	logic wbActive;

	// Register file, r0 never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < isaPkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbActive) begin
			regs[wbWrite.rd] <= wbWrite.writeData;
		end
	end

	assign wbActive = wbWrite.writeEn && (wbWrite.rd != '0);

	assign opField = ifId.instr[isaPkg::OP_MSB:isaPkg::OP_LSB];
	assign rdIdx = ifId.instr[isaPkg::RD_MSB:isaPkg::RD_LSB];
	assign rtIdx = ifId.instr[isaPkg::RT_MSB:isaPkg::RT_LSB];
	assign rsIdx = ifId.instr[isaPkg::RS_MSB:isaPkg::RS_LSB];

	// Unknown encodings decode as NOP
	always_comb begin
		case (opField)
			isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR, isaPkg::ADDI,
			isaPkg::LW, isaPkg::SW, isaPkg::BEQ, isaPkg::HALT:
				op = isaPkg::opcodeT'(opField);
			default:
				op = isaPkg::NOP;
		endcase
	end

	// SW and BEQ read rd as their second operand
	assign srcIdx = (op == isaPkg::SW || op == isaPkg::BEQ) ? rdIdx : rtIdx;
	assign useSrc = op inside {isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR,
		isaPkg::SW, isaPkg::BEQ};

	// Same-cycle writeback is visible to the read
	assign rsVal = (wbActive && wbWrite.rd == rsIdx) ? wbWrite.writeData : regs[rsIdx];
	assign srcVal = (wbActive && wbWrite.rd == srcIdx) ? wbWrite.writeData : regs[srcIdx];

	always_comb begin
		idEx = '0;
		idEx.op = op;
		idEx.rsIdx = rsIdx;
		idEx.rsVal = rsVal;
		idEx.srcIdx = srcIdx;
		idEx.srcVal = srcVal;
		idEx.rd = rdIdx;
		idEx.imm = {{(isaPkg::DATA_W - isaPkg::IMM_W){ifId.instr[isaPkg::IMM_MSB]}},
			ifId.instr[isaPkg::IMM_MSB:isaPkg::IMM_LSB]};
		idEx.pc = ifId.pc;
		idEx.writeEn = op inside {isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR,
			isaPkg::ADDI, isaPkg::LW};
		idEx.memRead = (op == isaPkg::LW);
	end

endmodule

/* ExecuteStage.sv */
// Execute stage: operand forwarding muxes, ALU, BEQ compare and target
`timescale 1ns/1ps

module ExecuteStage (
	input  pipePkg::idExT idEx,
	input  pipePkg::fwdSelT fwdA,
	input  pipePkg::fwdSelT fwdB,
	input  logic [isaPkg::DATA_W-1:0] memResult,
	input  logic [isaPkg::DATA_W-1:0] wbResult,
	output pipePkg::exMemT exMem,
	output logic branchTaken,
	output logic [isaPkg::ADDR_W-1:0] branchTarget
);

	logic [isaPkg::DATA_W-1:0] opA;
	logic [isaPkg::DATA_W-1:0] opB;
	logic [isaPkg::DATA_W-1:0] result;

	function automatic logic [isaPkg::DATA_W-1:0] pickOperand(
		input pipePkg::fwdSelT sel,
		input logic [isaPkg::DATA_W-1:0] regVal,
		input logic [isaPkg::DATA_W-1:0] memVal,
		input logic [isaPkg::DATA_W-1:0] wbVal
	);
		case (sel)
			pipePkg::FROM_MEM: return memVal;
			pipePkg::FROM_WB:  return wbVal;
			default:           return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, idEx.rsVal, memResult, wbResult);
	assign opB = pickOperand(fwdB, idEx.srcVal, memResult, wbResult);

	always_comb begin
		case (idEx.op)
			isaPkg::ADD: result = opA + opB;
			isaPkg::SUB: result = opA - opB;
			isaPkg::AND: result = opA & opB;
			isaPkg::OR:  result = opA | opB;
			// Address forms share the immediate add
			isaPkg::ADDI, isaPkg::LW, isaPkg::SW: result = opA + idEx.imm;
			default: result = '0;
		endcase
	end

	always_comb begin
		exMem = '0;
		exMem.aluResult = result;
		exMem.storeData = opB;
		exMem.rd = idEx.rd;
		exMem.writeEn = idEx.writeEn;
		exMem.memRead = idEx.memRead;
		exMem.memWrite = (idEx.op == isaPkg::SW);
		exMem.halt = (idEx.op == isaPkg::HALT);
	end

	assign branchTaken = (idEx.op == isaPkg::BEQ) && (opA == opB);

	// Target wraps in the 256-word space
	assign branchTarget = idEx.pc + idEx.imm[isaPkg::ADDR_W-1:0] + isaPkg::ADDR_W'(1);

endmodule

/* FetchStage.sv */
// Fetch stage: program counter with stall, halt freeze and branch redirect
`timescale 1ns/1ps

module FetchStage (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,
	input  logic redirect,
	input  logic [isaPkg::ADDR_W-1:0] redirectPc,
	input  logic halt,
	output logic [isaPkg::ADDR_W-1:0] imemAddr,
	output logic [isaPkg::ADDR_W-1:0] pc
);

	logic [isaPkg::ADDR_W-1:0] pcQ;

	// Halt wins over a late redirect from instructions still in flight
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pcQ <= '0;
		end else if (halt) begin
			pcQ <= pcQ;
		end else if (redirect) begin
			pcQ <= redirectPc;
		end else if (!stall) begin
			pcQ <= pcQ + isaPkg::ADDR_W'(1);
		end
	end

	assign imemAddr = pcQ;
	assign pc = pcQ;

	// A load-use stall and a taken branch need different instructions in execute
	assert property (@(posedge clk) disable iff (!rst_n) !(redirect && stall))
		else $error("redirect and stall asserted together");

endmodule

/* ForwardingUnit.sv */
// Forwarding unit: operand source selection for execute from memory and writeback
`timescale 1ns/1ps

module ForwardingUnit (
	input  logic [isaPkg::REG_ADDR_W-1:0] rsIdx,
	input  logic [isaPkg::REG_ADDR_W-1:0] srcIdx,
	input  logic [isaPkg::REG_ADDR_W-1:0] memRd,
	input  logic memWriteEn,
	input  logic [isaPkg::REG_ADDR_W-1:0] wbRd,
	input  logic wbWriteEn,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB
);

	// Newer result in memory takes priority
	function automatic pipePkg::fwdSelT chooseSource(
		input logic [isaPkg::REG_ADDR_W-1:0] idx
	);
		if (idx == '0)
			return pipePkg::REGFILE;
		if (memWriteEn && memRd == idx)
			return pipePkg::FROM_MEM;
		if (wbWriteEn && wbRd == idx)
			return pipePkg::FROM_WB;
		return pipePkg::REGFILE;
	endfunction

	assign fwdA = chooseSource(rsIdx);
	assign fwdB = chooseSource(srcIdx);

endmodule

/* HazardUnit.sv */
// Hazard unit: load-use detection between decode and execute
`timescale 1ns/1ps

module HazardUnit (
	input  logic [isaPkg::REG_ADDR_W-1:0] rsIdx,
	input  logic [isaPkg::REG_ADDR_W-1:0] srcIdx,
	input  logic useSrc,
	input  logic [isaPkg::REG_ADDR_W-1:0] exRd,
	input  logic exMemRead,
	output logic stall
);

	logic rsHit;
	logic srcHit;

	// rs counts as read for every opcode, harmless extra stall on HALT
	assign rsHit = (rsIdx == exRd);
	assign srcHit = useSrc && (srcIdx == exRd);

	// One bubble lets the load reach writeback before the use reaches execute
	assign stall = exMemRead && (exRd != '0) && (rsHit || srcHit);

endmodule

/* MemoryStage.sv */
// Memory stage: data memory port drive and writeback data select
`timescale 1ns/1ps

module MemoryStage (
	input  pipePkg::exMemT exMem,
	input  logic [isaPkg::DATA_W-1:0] dmemRdata,
	output logic [isaPkg::ADDR_W-1:0] dmemAddr,
	output logic [isaPkg::DATA_W-1:0] dmemWdata,
	output logic dmemWe,
	output logic dmemRe,
	output pipePkg::memWbT memWb,
	output logic [isaPkg::DATA_W-1:0] memResult
);

	// Word address is the low bits of the sum
	assign dmemAddr = exMem.aluResult[isaPkg::ADDR_W-1:0];
	assign dmemWdata = exMem.storeData;
	assign dmemWe = exMem.memWrite;
	assign dmemRe = exMem.memRead;

	// Load value arrives in the same cycle
	always_comb begin
		memWb = '0;
		memWb.writeData = exMem.memRead ? dmemRdata : exMem.aluResult;
		memWb.rd = exMem.rd;
		memWb.writeEn = exMem.writeEn;
		memWb.halt = exMem.halt;
	end

	// Loads never forward from here, the hazard unit keeps them out of reach
	assign memResult = exMem.aluResult;

endmodule

/* Processor.sv */
// Processor top: stage instances, pipeline registers, stall/flush control, halt latch
`timescale 1ns/1ps

module Processor (
	input  logic clk,
	input  logic rst_n,
	input  logic [isaPkg::DATA_W-1:0] imemData,
	input  logic [isaPkg::DATA_W-1:0] dmemRdata,
	output logic [isaPkg::ADDR_W-1:0] imemAddr,
	output logic [isaPkg::ADDR_W-1:0] dmemAddr,
	output logic [isaPkg::DATA_W-1:0] dmemWdata,
	output logic dmemWe,
	output logic dmemRe,
	output logic halt
);

	pipePkg::ifIdT ifIdD;
	pipePkg::ifIdT ifIdQ;
	pipePkg::idExT idExD;
	pipePkg::idExT idExQ;
	pipePkg::exMemT exMemD;
	pipePkg::exMemT exMemQ;
	pipePkg::memWbT memWbD;
	pipePkg::memWbT memWbQ;
	pipePkg::fwdSelT fwdA;
	pipePkg::fwdSelT fwdB;

	logic [isaPkg::ADDR_W-1:0] fetchPc;
	logic [isaPkg::ADDR_W-1:0] branchTarget;
	logic [isaPkg::REG_ADDR_W-1:0] decRsIdx;
	logic [isaPkg::REG_ADDR_W-1:0] decSrcIdx;
	logic [isaPkg::DATA_W-1:0] memResult;
	logic decUseSrc;
	logic branchTaken;
	logic stall;
	logic memWe;
	logic haltQ;
	logic haltSeen;
	logic flushYoung;

	FetchStage uFetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.redirect  (branchTaken),
		.redirectPc(branchTarget),
		.halt      (haltQ),
		.imemAddr  (imemAddr),
		.pc        (fetchPc)
	);

	assign ifIdD.instr = imemData;
	assign ifIdD.pc = fetchPc;

	DecodeStage uDecode (
		.clk    (clk),
		.rst_n  (rst_n),
		.ifId   (ifIdQ),
		.wbWrite(memWbQ),
		.idEx   (idExD),
		.rsIdx  (decRsIdx),
		.srcIdx (decSrcIdx),
		.useSrc (decUseSrc)
	);

	ExecuteStage uExecute (
		.idEx        (idExQ),
		.fwdA        (fwdA),
		.fwdB        (fwdB),
		.memResult   (memResult),
		.wbResult    (memWbQ.writeData),
		.exMem       (exMemD),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget)
	);

	MemoryStage uMemory (
		.exMem    (exMemQ),
		.dmemRdata(dmemRdata),
		.dmemAddr (dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWe   (memWe),
		.dmemRe   (dmemRe),
		.memWb    (memWbD),
		.memResult(memResult)
	);

	ForwardingUnit uForward (
		.rsIdx     (idExQ.rsIdx),
		.srcIdx    (idExQ.srcIdx),
		.memRd     (exMemQ.rd),
		.memWriteEn(exMemQ.writeEn),
		.wbRd      (memWbQ.rd),
		.wbWriteEn (memWbQ.writeEn),
		.fwdA      (fwdA),
		.fwdB      (fwdB)
	);

	HazardUnit uHazard (
		.rsIdx    (decRsIdx),
		.srcIdx   (decSrcIdx),
		.useSrc   (decUseSrc),
		.exRd     (idExQ.rd),
		.exMemRead(idExQ.memRead),
		.stall    (stall)
	);

	// Nothing younger than a HALT in execute or later may proceed
	assign haltSeen = (idExQ.op == isaPkg::HALT) || exMemQ.halt || memWbQ.halt || haltQ;
	assign flushYoung = branchTaken || haltSeen;

	always_ff @(posedge clk) begin
		if (!rst_n || flushYoung) begin
			ifIdQ <= '0;
		end else if (!stall) begin
			ifIdQ <= ifIdD;
		end
	end

	// Bubble on load-use stall
	always_ff @(posedge clk) begin
		if (!rst_n || flushYoung || stall) begin
			idExQ <= '0;
		end else begin
			idExQ <= idExD;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMemQ <= '0;
			memWbQ <= '0;
		end else begin
			exMemQ <= exMemD;
			memWbQ <= memWbD;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			haltQ <= 1'b0;
		end else if (memWbQ.halt) begin
			haltQ <= 1'b1;
		end
	end

	assign halt = haltQ;
	assign dmemWe = memWe && !haltQ;

	assert property (@(posedge clk) disable iff (!rst_n) !(dmemWe && dmemRe))
		else $error("dmemWe and dmemRe high together");

endmodule

/* all.f */
isaPkg.sv
pipePkg.sv
FetchStage.sv
DecodeStage.sv
ExecuteStage.sv
MemoryStage.sv
ForwardingUnit.sv
HazardUnit.sv
Processor.sv
tbProcessor.sv

/* isaPkg.sv */
// Instruction set definitions: opcode enum, instruction field positions, widths, memory depths
package isaPkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT = 32;
	localparam int OP_W = 6;
	localparam int IMM_W = 16;

	// Word-addressed, both 256 deep
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	// Instruction fields
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 26;
	localparam int RD_MSB = 25;
	localparam int RD_LSB = 21;
	localparam int RS_MSB = 20;
	localparam int RS_LSB = 16;
	localparam int RT_MSB = 15;
	localparam int RT_LSB = 11;
	localparam int IMM_LSB = 0;
	localparam int IMM_MSB = IMM_LSB + IMM_W - 1;

	typedef enum logic [OP_W-1:0] {
		NOP  = 6'd0,
		ADD  = 6'd1,
		SUB  = 6'd2,
		AND  = 6'd3,
		OR   = 6'd4,
		ADDI = 6'd5,
		LW   = 6'd6,
		SW   = 6'd7,
		BEQ  = 6'd8,
		HALT = 6'd9
	} opcodeT;

endpackage

/* pipePkg.sv */
// Pipeline definitions: stage-register structs and the forwarding source selector
package pipePkg;

	// IF/ID
	typedef struct packed {
		logic [isaPkg::DATA_W-1:0] instr;
		logic [isaPkg::ADDR_W-1:0] pc;
	} ifIdT;

	// ID/EX, second source is rt for ALU ops and rd for SW and BEQ
	typedef struct packed {
		isaPkg::opcodeT op;
		logic [isaPkg::REG_ADDR_W-1:0] rsIdx;
		logic [isaPkg::DATA_W-1:0] rsVal;
		logic [isaPkg::REG_ADDR_W-1:0] srcIdx;
		logic [isaPkg::DATA_W-1:0] srcVal;
		logic [isaPkg::REG_ADDR_W-1:0] rd;
		logic [isaPkg::DATA_W-1:0] imm;
		logic [isaPkg::ADDR_W-1:0] pc;
		logic writeEn;
		logic memRead;
	} idExT;

	// EX/MEM
	typedef struct packed {
		logic [isaPkg::DATA_W-1:0] aluResult;
		logic [isaPkg::DATA_W-1:0] storeData;
		logic [isaPkg::REG_ADDR_W-1:0] rd;
		logic writeEn;
		logic memRead;
		logic memWrite;
		logic halt;
	} exMemT;

	// MEM/WB
	typedef struct packed {
		logic [isaPkg::DATA_W-1:0] writeData;
		logic [isaPkg::REG_ADDR_W-1:0] rd;
		logic writeEn;
		logic halt;
	} memWbT;

	typedef enum logic [1:0] {
		REGFILE  = 2'd0,
		FROM_MEM = 2'd1,
		FROM_WB  = 2'd2
	} fwdSelT;

endpackage

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tbProcessor -o simProcessor \
	&& ./obj_dir/simProcessor | tee /dev/stderr | grep -q "Test passed" \
	&& echo "simulation run: PASS" \
	|| { echo "simulation run: FAIL"; exit 1; }

/* tbProcessor.sv */
// Testbench for Processor: random program generator, memories, ISA reference model, checks
`timescale 1ns/1ps

module tbProcessor;

	localparam logic [31:0] SEED = 32'hd8e0_7673;
	localparam int PROG_LEN = 40;
	localparam int PROGRAMS_PER_TEST = 4;
	localparam int RESET_CYCLES = 4;
	localparam int ABORT_CYCLES = 30;
	localparam int QUIET_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int MODEL_STEP_LIMIT = 1000;

	logic clk;
	logic rst_n;
	logic initReq;
	logic [31:0] imemData;
	logic [31:0] dmemRdata;
	logic [7:0] imemAddr;
	logic [7:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic dmemWe;
	logic dmemRe;
	logic halt;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] lcgState;
	logic [7:0] expAddr [$];
	logic [31:0] expData [$];
	logic [7:0] gotAddr [$];
	logic [31:0] gotData [$];
	int errorCount;
	int testsRun;
	int testsFailed;

	Processor uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.imemData (imemData),
		.dmemRdata(dmemRdata),
		.imemAddr (imemAddr),
		.dmemAddr (dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWe   (dmemWe),
		.dmemRe   (dmemRe),
		.halt     (halt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Both memories answer in the same cycle
	assign imemData = imem[imemAddr];
	assign dmemRdata = dmem[dmemAddr];

	function automatic logic [31:0] memFill(input logic [7:0] addr);
		return {addr, ~addr, addr ^ 8'h5a, addr + 8'd37};
	endfunction

	always @(posedge clk) begin
		if (initReq) begin
			for (int i = 0; i < 256; i++) begin
				dmem[8'(i)] <= memFill(8'(i));
			end
		end else if (dmemWe) begin
			dmem[dmemAddr] <= dmemWdata;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = nextRand();
		return int'((r >> 8) % 32'(n));
	endfunction

	function automatic logic [4:0] pickReg(input int span);
		return 5'(randBelow(span));
	endfunction

	function automatic logic [31:0] encReg(input isaPkg::opcodeT op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {op, rd, rs, rt, 11'd0};
	endfunction

	function automatic logic [31:0] encImm(input isaPkg::opcodeT op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	// Small register span keeps results flowing into the next few instructions
	function automatic logic [31:0] randomAlu(input int span, input int immSpan);
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
		int kind;
		kind = randBelow(5);
		rd = pickReg(span);
		rs = pickReg(span);
		rt = pickReg(span);
		imm = 16'(randBelow(immSpan == 0 ? 65536 : immSpan));
		case (kind)
			0: return encReg(isaPkg::ADD, rd, rs, rt);
			1: return encReg(isaPkg::SUB, rd, rs, rt);
			2: return encReg(isaPkg::AND, rd, rs, rt);
			3: return encReg(isaPkg::OR, rd, rs, rt);
			default: return encImm(isaPkg::ADDI, rd, rs, imm);
		endcase
	endfunction

	// Style 0 ALU, 1 load-use pairs, 2 forward branches, 3 a mix of all
	task automatic emitSlot(input int style, inout int pc);
		int kind;
		int imm;
		logic [4:0] dst;
		kind = (style == 3) ? randBelow(3) : style;
		case (kind)
			1: begin
				if (randBelow(3) == 0 && pc + 1 < PROG_LEN) begin
					dst = 5'(1 + randBelow(7));
					imem[8'(pc)] = encImm(isaPkg::LW, dst, pickReg(8), 16'(randBelow(64)));
					case (randBelow(3))
						0: imem[8'(pc + 1)] = encReg(isaPkg::ADD, pickReg(8), dst, pickReg(8));
						1: imem[8'(pc + 1)] = encReg(isaPkg::SUB, pickReg(8), pickReg(8), dst);
						default: imem[8'(pc + 1)] = encImm(isaPkg::SW, dst, pickReg(8),
							16'(randBelow(64)));
					endcase
					pc += 2;
				end else begin
					imem[8'(pc)] = randomAlu(8, 0);
					pc++;
				end
			end
			2: begin
				dst = pickReg(4);
				case (randBelow(4))
					0: begin
						// Target never passes the start of the register dump
						imm = randBelow(4);
						if (imm > PROG_LEN - pc - 1) begin
							imm = PROG_LEN - pc - 1;
						end
						imem[8'(pc)] = encImm(isaPkg::BEQ, dst, pickReg(4), 16'(imm));
					end
					1: imem[8'(pc)] = encImm(isaPkg::SW, dst, 5'd0, 16'(randBelow(32)));
					default: imem[8'(pc)] = randomAlu(4, 4);
				endcase
				pc++;
			end
			default: begin
				imem[8'(pc)] = randomAlu(8, 0);
				pc++;
			end
		endcase
	endtask

	task automatic buildProgram(input int style);
		int pc;
		for (int i = 0; i < 256; i++) begin
			imem[8'(i)] = 32'd0;
		end
		pc = 0;
		while (pc < PROG_LEN) begin
			emitSlot(style, pc);
		end
		// Dump r1..r31 to 224..254, then stop
		for (int r = 1; r < 32; r++) begin
			imem[8'(PROG_LEN + r - 1)] = encImm(isaPkg::SW, 5'(r), 5'd0, 16'(223 + r));
		end
		imem[8'(PROG_LEN + 31)] = encImm(isaPkg::HALT, 5'd0, 5'd0, 16'd0);
	endtask

	// One instruction at a time, straight from the instruction set rules
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] imm;
		logic [7:0] pc;
		logic [7:0] addr;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		isaPkg::opcodeT op;
		int steps;
		bit done;
		expAddr.delete();
		expData.delete();
		for (int i = 0; i < 32; i++) begin
			regs[5'(i)] = 32'd0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[8'(i)] = memFill(8'(i));
		end
		pc = 8'd0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < MODEL_STEP_LIMIT) begin
			instr = imem[pc];
			op = isaPkg::opcodeT'(instr[31:26]);
			rd = instr[25:21];
			rs = instr[20:16];
			rt = instr[15:11];
			imm = {{16{instr[15]}}, instr[15:0]};
			a = regs[rs];
			pc = pc + 8'd1;
			case (op)
				isaPkg::ADD: regs[rd] = a + regs[rt];
				isaPkg::SUB: regs[rd] = a - regs[rt];
				isaPkg::AND: regs[rd] = a & regs[rt];
				isaPkg::OR: regs[rd] = a | regs[rt];
				isaPkg::ADDI: regs[rd] = a + imm;
				isaPkg::LW: regs[rd] = mem[8'(a + imm)];
				isaPkg::SW: begin
					addr = 8'(a + imm);
					mem[addr] = regs[rd];
					expAddr.push_back(addr);
					expData.push_back(regs[rd]);
				end
				isaPkg::BEQ: begin
					if (a == regs[rd]) begin
						pc = pc + imm[7:0];
					end
				end
				isaPkg::HALT: done = 1'b1;
				default: ;
			endcase
			regs[0] = 32'd0;
			steps++;
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("Fail at time %0t: %s expected 0x%08h got 0x%08h", $time, name,
				expected, actual);
			errorCount++;
		end
	endtask

	// Reset held for RESET_CYCLES edges, returns in the first cycle after it
	task automatic applyReset(input bit checkOutputs);
		@(posedge clk);
		rst_n <= 1'b0;
		initReq <= 1'b1;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			initReq <= 1'b0;
			if (i == RESET_CYCLES - 1) begin
				rst_n <= 1'b1;
			end
			@(negedge clk);
			if (checkOutputs) begin
				checkValue("halt", 32'd0, 32'(halt));
				checkValue("dmemWe", 32'd0, 32'(dmemWe));
				checkValue("dmemRe", 32'd0, 32'(dmemRe));
				checkValue("imemAddr", 32'd0, 32'(imemAddr));
			end
		end
	endtask

	task automatic collectStores();
		int cycles;
		gotAddr.delete();
		gotData.delete();
		cycles = 0;
		while (!halt && cycles < TIMEOUT_CYCLES) begin
			if (dmemWe) begin
				gotAddr.push_back(dmemAddr);
				gotData.push_back(dmemWdata);
			end
			@(negedge clk);
			cycles++;
		end
		assert (halt)
		else begin
			$display("Timeout: halt did not rise within %0d cycles", TIMEOUT_CYCLES);
			errorCount++;
		end
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			assert (!dmemWe)
			else begin
				$display("Fail at time %0t: dmemWe expected 0 got 1 after halt", $time);
				errorCount++;
			end
			checkValue("halt", 32'd1, 32'(halt));
		end
	endtask

	task automatic compareStores();
		checkValue("store count", 32'(expAddr.size()), 32'(gotAddr.size()));
		for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
			checkValue($sformatf("dmemAddr (store %0d)", i), 32'(expAddr[i]), 32'(gotAddr[i]));
			checkValue($sformatf("dmemWdata (store %0d)", i), expData[i], gotData[i]);
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		testsRun++;
		if (errorCount != errBefore) begin
			testsFailed++;
		end
		$display("test %0d %s: %s", num, name, (errorCount == errBefore) ? "ok" : "FAILED");
	endtask

	task automatic runTest(input int num, input string name, input int style,
		input bit midReset);
		int errBefore;
		errBefore = errorCount;
		for (int p = 0; p < PROGRAMS_PER_TEST; p++) begin
			buildProgram(style);
			runModel();
			if (midReset) begin
				applyReset(1'b0);
				for (int c = 0; c < ABORT_CYCLES; c++) begin
					@(negedge clk);
				end
			end
			applyReset(1'b0);
			collectStores();
			compareStores();
		end
		reportTest(num, name, errBefore);
	endtask

	initial begin
		int errBefore;
		rst_n = 1'b0;
		initReq = 1'b0;
		lcgState = SEED;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		buildProgram(0);
		errBefore = errorCount;
		applyReset(1'b1);
		reportTest(1, "reset values", errBefore);
		runTest(2, "alu forwarding", 0, 1'b0);
		runTest(3, "load-use stall", 1, 1'b0);
		runTest(4, "branch flush", 2, 1'b0);
		runTest(5, "halt and store count", 3, 1'b0);
		runTest(6, "reset mid-program", 3, 1'b1);
		$display("Summary: %0d tests, %0d with errors, %0d errors in total", testsRun,
			testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
